// ==== Bender.yml ====
package:
  name: cmd_unit

sources:
  - hw/cmdPkg.sv
  - hw/cmdFifo.sv
  - hw/cmdDecode.sv
  - hw/cmdExecute.sv
  - hw/resultStage.sv
  - hw/cmdUnit.sv
  - target: test
    files:
      - test/cmdUnitChecker.sv
      - test/cmdUnitTb.sv

// ==== files.f ====
hw/cmdPkg.sv
hw/cmdFifo.sv
hw/cmdDecode.sv
hw/cmdExecute.sv
hw/resultStage.sv
hw/cmdUnit.sv
test/cmdUnitChecker.sv
test/cmdUnitTb.sv

// ==== hw/cmdDecode.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmdDecode (
  input  logic             RClk,
  input  logic             PresetEmpty,
  input  cmdPkg::cmdWord   head,
  input  logic             fifoEmpty,
  input  logic             stall,
  output logic             pop,
  output cmdPkg::decodedOp op
);

  logic             headValid;
  cmdPkg::decodedOp opNext;

  // Pop whenever a word waits and the pipe can move
  assign pop = !fifoEmpty && !stall;

  // Split the word through the view its kind bit selects
  always_comb begin
    opNext.valid  = headValid;
    opNext.isLoad = head.alu.kind;
    if (head.alu.kind) begin
      opNext.op   = cmdPkg::OpPass;
      opNext.dst  = head.load.dst;
      opNext.srcA = '0;
      opNext.srcB = '0;
      opNext.emit = head.load.emit;
      opNext.imm  = head.load.imm;
    end else begin
      opNext.op   = head.alu.op;
      opNext.dst  = head.alu.dst;
      opNext.srcA = head.alu.srcA;
      opNext.srcB = head.alu.srcB;
      opNext.emit = head.alu.emit;
      opNext.imm  = '0;
    end
  end

  // Head word is valid the cycle after its pop
  always_ff @(posedge RClk) begin
    if (PresetEmpty) begin
      headValid <= 1'b0;
      op        <= '0;
    end else if (!stall) begin
      headValid <= pop;
      op        <= opNext;
    end
  end

endmodule

`default_nettype wire

// ==== hw/cmdExecute.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmdExecute (
  input  logic             RClk,
  input  logic             PresetEmpty,
  input  cmdPkg::decodedOp op,
  input  logic             stall,
  output cmdPkg::resultRec resOut,
  output logic             resValid
);

  logic [cmdPkg::DataWidth-1:0] regFile [cmdPkg::RegCount];

  logic [cmdPkg::DataWidth-1:0] opA;
  logic [cmdPkg::DataWidth-1:0] opB;
  logic [cmdPkg::DataWidth-1:0] aluResult;
  logic [cmdPkg::DataWidth-1:0] value;
  logic                         resValidReg;

  // Operands read from current register state
  assign opA = regFile[op.srcA];
  assign opB = regFile[op.srcB];

  always_comb begin
    aluResult = opA;
    case (op.op)
      cmdPkg::OpAdd:  aluResult = opA + opB;
      cmdPkg::OpSub:  aluResult = opA - opB;
      cmdPkg::OpAnd:  aluResult = opA & opB;
      cmdPkg::OpOr:   aluResult = opA | opB;
      cmdPkg::OpXor:  aluResult = opA ^ opB;
      cmdPkg::OpShl:  aluResult = opA << 1;
      cmdPkg::OpShr:  aluResult = opA >> 1;
      cmdPkg::OpPass: aluResult = opA;
    endcase
  end

  assign value = op.isLoad ? op.imm : aluResult;

  // Register write and result record in the same edge
  always_ff @(posedge RClk) begin
    if (PresetEmpty) begin
      for (int i = 0; i < cmdPkg::RegCount; i++) begin
        regFile[i] <= '0;
      end
      resOut      <= '0;
      resValidReg <= 1'b0;
    end else if (!stall) begin
      resValidReg <= op.valid && op.emit;
      if (op.valid) begin
        regFile[op.dst] <= value;
        resOut.dst      <= op.dst;
        resOut.value    <= value;
      end
    end
  end

  // Pending record is offered again once the stall drops
  assign resValid = resValidReg && !stall;

endmodule

`default_nettype wire

// ==== hw/cmdFifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmdFifo #(
  parameter int DataWidth = 16,
  parameter int AddrWidth = 4
) (
  input  logic                 RClk,
  input  logic                 PresetEmpty,
  input  logic                 writeEn,
  input  logic [DataWidth-1:0] writeData,
  input  logic                 readEn,
  output logic [DataWidth-1:0] readData,
  output logic                 full,
  output logic                 empty
);

  logic [DataWidth-1:0] mem [2**AddrWidth];

  logic [AddrWidth-1:0] wPtr;
  logic [AddrWidth-1:0] rPtr;
  logic [AddrWidth-1:0] wPtrNext;
  logic [AddrWidth-1:0] rPtrNext;
  logic                 writeAcc;
  logic                 readAcc;
  logic [1:0]           wQuad;
  logic [1:0]           rQuad;
  logic                 dirSet;
  logic                 dirClr;
  logic                 direction;
  logic                 dirNext;
  logic                 ptrsEqualNext;

  // Writes while full are dropped, reads while empty ignored
  assign writeAcc = writeEn && !full;
  assign readAcc  = readEn && !empty;

  always_comb begin
    wPtrNext = writeAcc ? wPtr + 1'b1 : wPtr;
    rPtrNext = readAcc ? rPtr + 1'b1 : rPtr;
    // Quadrant is the top two pointer bits
    wQuad = wPtrNext[AddrWidth-1 -: 2];
    rQuad = rPtrNext[AddrWidth-1 -: 2];
    // Writer one quadrant behind reader means we are heading for full
    dirSet = 2'(wQuad + 2'd1) == rQuad;
    // Reader one quadrant behind writer means heading for empty
    dirClr = 2'(rQuad + 2'd1) == wQuad;
    if (dirSet) begin
      dirNext = 1'b1;
    end else if (dirClr) begin
      dirNext = 1'b0;
    end else begin
      dirNext = direction;
    end
    ptrsEqualNext = wPtrNext == rPtrNext;
  end

  // Pointers, direction and flags
  always_ff @(posedge RClk) begin
    if (PresetEmpty) begin
      wPtr      <= '0;
      rPtr      <= '0;
      direction <= 1'b0;
      full      <= 1'b0;
      empty     <= 1'b1;
    end else begin
      wPtr      <= wPtrNext;
      rPtr      <= rPtrNext;
      direction <= dirNext;
      // Flags from the next state so they are exact after every edge
      full      <= dirNext && ptrsEqualNext;
      empty     <= !dirNext && ptrsEqualNext;
    end
  end

  always_ff @(posedge RClk) begin
    if (writeAcc) begin
      mem[wPtr] <= writeData;
    end
  end

  // Read data stays until the next accepted read
  always_ff @(posedge RClk) begin
    if (PresetEmpty) begin
      readData <= '0;
    end else if (readAcc) begin
      readData <= mem[rPtr];
    end
  end

  noFullAndEmpty: assert property (@(posedge RClk) disable iff (PresetEmpty)
    !(full && empty));

  // A read always frees an entry, a write always fills one
  readLeavesRoom: assert property (@(posedge RClk) disable iff (PresetEmpty)
    readAcc |=> !full);

  writeLeavesData: assert property (@(posedge RClk) disable iff (PresetEmpty)
    writeAcc |=> !empty);

endmodule

`default_nettype wire

// ==== hw/cmdPkg.sv ====
`default_nettype none

package cmdPkg;

  // Register file and data path sizes
  localparam int RegCount    = 4;
  localparam int RegIdxWidth = $clog2(RegCount);
  localparam int DataWidth   = 8;

  // Command word and FIFO depths
  localparam int CmdWidth     = 16;
  localparam int CmdAddrWidth = 4;
  localparam int ResAddrWidth = 3;

  // ALU operations, results truncated to DataWidth
  typedef enum logic [2:0] {
    OpAdd  = 3'd0,
    OpSub  = 3'd1,
    OpAnd  = 3'd2,
    OpOr   = 3'd3,
    OpXor  = 3'd4,
    OpShl  = 3'd5,
    OpShr  = 3'd6,
    OpPass = 3'd7
  } opCode;

  // Register to register form, kind is 0
  typedef struct packed {
    logic                   kind;
    opCode                  op;
    logic [RegIdxWidth-1:0] dst;
    logic [RegIdxWidth-1:0] srcA;
    logic [RegIdxWidth-1:0] srcB;
    logic                   emit;
    logic [4:0]             pad;
  } aluForm;

  // Immediate load form, kind is 1
  typedef struct packed {
    logic                   kind;
    logic [RegIdxWidth-1:0] dst;
    logic                   emit;
    logic [3:0]             pad;
    logic [DataWidth-1:0]   imm;
  } loadForm;

  // Top bit picks the view
  typedef union packed {
    aluForm  alu;
    loadForm load;
  } cmdWord;

  typedef struct packed {
    logic                   valid;
    logic                   isLoad;
    opCode                  op;
    logic [RegIdxWidth-1:0] dst;
    logic [RegIdxWidth-1:0] srcA;
    logic [RegIdxWidth-1:0] srcB;
    logic                   emit;
    logic [DataWidth-1:0]   imm;
  } decodedOp;

  typedef struct packed {
    logic [RegIdxWidth-1:0] dst;
    logic [DataWidth-1:0]   value;
  } resultRec;

endpackage

`default_nettype wire

// ==== hw/cmdUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmdUnit (
  input  logic             RClk,
  input  logic             PresetEmpty,
  input  logic             cmdWrite,
  input  cmdPkg::cmdWord   cmdData,
  input  logic             resRead,
  output logic             cmdFull,
  output cmdPkg::resultRec resData,
  output logic             resEmpty
);

  cmdPkg::cmdWord   head;
  logic             cmdEmpty;
  logic             pop;
  logic             stall;
  cmdPkg::decodedOp decOp;
  cmdPkg::resultRec exeRes;
  logic             exeValid;
  logic             resFifoWrite;
  cmdPkg::resultRec resFifoData;
  logic             resFull;

  // Host command queue
  cmdFifo #(
    .DataWidth(cmdPkg::CmdWidth),
    .AddrWidth(cmdPkg::CmdAddrWidth)
  ) cmdQueue (
    .RClk       (RClk),
    .PresetEmpty(PresetEmpty),
    .writeEn    (cmdWrite),
    .writeData  (cmdData),
    .readEn     (pop),
    .readData   (head),
    .full       (cmdFull),
    .empty      (cmdEmpty)
  );

  cmdDecode decode (
    .RClk       (RClk),
    .PresetEmpty(PresetEmpty),
    .head       (head),
    .fifoEmpty  (cmdEmpty),
    .stall      (stall),
    .pop        (pop),
    .op         (decOp)
  );

  cmdExecute execute (
    .RClk       (RClk),
    .PresetEmpty(PresetEmpty),
    .op         (decOp),
    .stall      (stall),
    .resOut     (exeRes),
    .resValid   (exeValid)
  );

  resultStage result (
    .RClk       (RClk),
    .PresetEmpty(PresetEmpty),
    .resIn      (exeRes),
    .resValid   (exeValid),
    .fifoFull   (resFull),
    .fifoWrite  (resFifoWrite),
    .fifoData   (resFifoData),
    .stall      (stall)
  );

  // Result queue read by the host
  cmdFifo #(
    .DataWidth($bits(cmdPkg::resultRec)),
    .AddrWidth(cmdPkg::ResAddrWidth)
  ) resQueue (
    .RClk       (RClk),
    .PresetEmpty(PresetEmpty),
    .writeEn    (resFifoWrite),
    .writeData  (resFifoData),
    .readEn     (resRead),
    .readData   (resData),
    .full       (resFull),
    .empty      (resEmpty)
  );

endmodule

`default_nettype wire

// ==== hw/resultStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module resultStage (
  input  logic             RClk,
  input  logic             PresetEmpty,
  input  cmdPkg::resultRec resIn,
  input  logic             resValid,
  input  logic             fifoFull,
  output logic             fifoWrite,
  output cmdPkg::resultRec fifoData,
  output logic             stall
);

  logic             held;
  cmdPkg::resultRec holdData;
  logic             capture;
  logic             drain;

  // Held record leaves first, new record bypasses when nothing is held
  assign fifoWrite = (held || resValid) && !fifoFull;
  assign fifoData  = held ? holdData : resIn;
  assign stall     = held && fifoFull;

  assign drain = held && !fifoFull;
  // New record parks when it cannot go straight in
  assign capture = resValid && (held ? !fifoFull : fifoFull);

  always_ff @(posedge RClk) begin
    if (PresetEmpty) begin
      held <= 1'b0;
    end else if (capture) begin
      held <= 1'b1;
    end else if (drain) begin
      held <= 1'b0;
    end
  end

  always_ff @(posedge RClk) begin
    if (PresetEmpty) begin
      holdData <= '0;
    end else if (capture) begin
      holdData <= resIn;
    end
  end

  // Execute must keep its record while this stage is blocked
  noResultWhileBlocked: assert property (@(posedge RClk) disable iff (PresetEmpty)
    resValid |-> !(held && fifoFull));

endmodule

`default_nettype wire

// ==== test/cmdUnitChecker.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmdUnitChecker (
  input  logic             RClk,
  input  logic             PresetEmpty,
  input  logic             cmdWrite,
  input  cmdPkg::cmdWord   cmdData,
  input  logic             cmdFull,
  input  logic             resRead,
  input  cmdPkg::resultRec resData,
  input  logic             resEmpty,
  input  logic             finalCheck,
  output int               valueErrors,
  output int               otherErrors,
  output int               pendingCount
);

  logic [7:0] modelRegs [4];
  logic [9:0] expQueue [$];
  string      nameQueue [$];
  logic       readPending;
  logic       fullSeen;
  int         emitCount;
  int         readCount;

  initial begin
    valueErrors  = 0;
    otherErrors  = 0;
    pendingCount = 0;
    readPending  = 1'b0;
    fullSeen     = 1'b0;
    emitCount    = 0;
    readCount    = 0;
    foreach (modelRegs[i]) modelRegs[i] = 8'h00;
  end

  // Op rules, everything truncated to a byte
  function automatic logic [7:0] aluModel(input logic [2:0] code, input logic [7:0] a,
                                          input logic [7:0] b);
    case (code)
      cmdPkg::OpAdd: aluModel = a + b;
      cmdPkg::OpSub: aluModel = a - b;
      cmdPkg::OpAnd: aluModel = a & b;
      cmdPkg::OpOr:  aluModel = a | b;
      cmdPkg::OpXor: aluModel = a ^ b;
      cmdPkg::OpShl: aluModel = {a[6:0], 1'b0};
      cmdPkg::OpShr: aluModel = {1'b0, a[7:1]};
      default:       aluModel = a;
    endcase
  endfunction

  function automatic string opName(input logic [2:0] code);
    case (code)
      cmdPkg::OpAdd: opName = "alu add";
      cmdPkg::OpSub: opName = "alu sub";
      cmdPkg::OpAnd: opName = "alu and";
      cmdPkg::OpOr:  opName = "alu or";
      cmdPkg::OpXor: opName = "alu xor";
      cmdPkg::OpShl: opName = "alu shl";
      cmdPkg::OpShr: opName = "alu shr";
      default:       opName = "alu pass";
    endcase
  endfunction

  // Bit fields taken straight from the command word layout
  task automatic applyCommand(input logic [15:0] word);
    logic [1:0] dst;
    logic [7:0] result;
    logic       emit;
    string      name;
    if (word[15]) begin
      dst    = word[14:13];
      emit   = word[12];
      result = word[7:0];
      name   = "load";
    end else begin
      dst    = word[11:10];
      emit   = word[5];
      result = aluModel(word[14:12], modelRegs[word[9:8]], modelRegs[word[7:6]]);
      name   = opName(word[14:12]);
    end
    modelRegs[dst] = result;
    if (emit) begin
      expQueue.push_back({dst, result});
      nameQueue.push_back(name);
      emitCount++;
    end
  endtask

  task automatic compareRead;
    logic [9:0] expected;
    string      name;
    readCount++;
    if (expQueue.size() == 0) begin
      $display("result read with nothing expected (dst %0d value %h), extra or duplicate",
               resData.dst, resData.value);
      otherErrors++;
    end else begin
      expected = expQueue.pop_front();
      name     = nameQueue.pop_front();
      if (resData !== expected) begin
        $display("error %s: expected dst %0d value %h, actual dst %0d value %h",
                 name, expected[9:8], expected[7:0], resData.dst, resData.value);
        valueErrors++;
      end
    end
  endtask

  task automatic runFinalChecks;
    if (readCount != emitCount) begin
      $display("error record count: expected %0d, actual %0d", emitCount, readCount);
      valueErrors++;
    end
    if (expQueue.size() != 0) begin
      $display("%0d expected results were never read back", expQueue.size());
      otherErrors++;
    end
    if (resEmpty !== 1'b1) begin
      $display("error final resEmpty: expected 1, actual %b", resEmpty);
      valueErrors++;
    end
    if (!fullSeen) begin
      $display("command FIFO never became full while reads were stopped");
      otherErrors++;
    end
  endtask

  // Inputs change just after the rising edge, so the falling edge sees them settled
  always @(negedge RClk) begin
    if (PresetEmpty) begin
      if (resEmpty !== 1'b1) begin
        $display("error reset resEmpty: expected 1, actual %b", resEmpty);
        valueErrors++;
      end
      if (cmdFull !== 1'b0) begin
        $display("error reset cmdFull: expected 0, actual %b", cmdFull);
        valueErrors++;
      end
      foreach (modelRegs[i]) modelRegs[i] = 8'h00;
      expQueue.delete();
      nameQueue.delete();
      readPending = 1'b0;
    end else begin
      // Read accepted at the edge just passed
      if (readPending) begin
        compareRead();
      end
      readPending = resRead && !resEmpty;
      if (cmdWrite && !cmdFull) begin
        applyCommand(cmdData);
      end
      if (cmdFull) begin
        fullSeen = 1'b1;
      end
      if (finalCheck) begin
        runFinalChecks();
      end
    end
    pendingCount = expQueue.size();
  end

endmodule

`default_nettype wire

// ==== test/cmdUnitTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmdUnitTb;

  localparam int ResetCycles   = 4;
  localparam int PhaseACycles  = 300;
  localparam int StopCycles    = 120;
  localparam int DrainMargin   = 200;
  localparam int TailCycles    = 30;
  localparam int TimeoutCycles = ResetCycles + PhaseACycles + StopCycles + DrainMargin;

  logic             RClk = 1'b0;
  logic             PresetEmpty;
  logic             cmdWrite;
  cmdPkg::cmdWord   cmdData;
  logic             resRead;
  logic             cmdFull;
  cmdPkg::resultRec resData;
  logic             resEmpty;
  logic             finalCheck;
  int               valueErrors;
  int               otherErrors;
  int               pendingCount;
  int               cycleCount = 0;
  integer           seed;
  logic [31:0]      choice;

  cmdUnit DUT (
    .RClk       (RClk),
    .PresetEmpty(PresetEmpty),
    .cmdWrite   (cmdWrite),
    .cmdData    (cmdData),
    .resRead    (resRead),
    .cmdFull    (cmdFull),
    .resData    (resData),
    .resEmpty   (resEmpty)
  );

  cmdUnitChecker scoreboard (
    .RClk        (RClk),
    .PresetEmpty (PresetEmpty),
    .cmdWrite    (cmdWrite),
    .cmdData     (cmdData),
    .cmdFull     (cmdFull),
    .resRead     (resRead),
    .resData     (resData),
    .resEmpty    (resEmpty),
    .finalCheck  (finalCheck),
    .valueErrors (valueErrors),
    .otherErrors (otherErrors),
    .pendingCount(pendingCount)
  );

  always #10 RClk = ~RClk;

  always @(posedge RClk) begin
    cycleCount <= cycleCount + 1;
  end

  // Writes go out only when the command FIFO has room
  task automatic driveCycle(input logic writeWanted, input logic readWanted);
    logic [31:0] word;
    word     = $random(seed);
    cmdWrite = writeWanted && !cmdFull;
    cmdData  = word[15:0];
    resRead  = readWanted;
  endtask

  initial begin
    wait (cycleCount >= TimeoutCycles);
    $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("errors: value %0d, other %0d", valueErrors, otherErrors);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    seed        = 14353;
    PresetEmpty = 1'b1;
    cmdWrite    = 1'b0;
    cmdData     = '0;
    resRead     = 1'b0;
    finalCheck  = 1'b0;
    repeat (ResetCycles) @(posedge RClk);
    #2 PresetEmpty = 1'b0;

    // Mixed traffic with reads half the time
    repeat (PhaseACycles) begin
      @(posedge RClk);
      #2;
      choice = $random(seed);
      driveCycle(choice[0], choice[1]);
    end

    // Host stops reading so back-pressure reaches the command FIFO
    repeat (StopCycles) begin
      @(posedge RClk);
      #2;
      driveCycle(1'b1, 1'b0);
    end

    // Drain until every expected result has come back
    while (pendingCount != 0) begin
      @(posedge RClk);
      #2;
      driveCycle(1'b0, 1'b1);
    end
    // Keep reading a while to catch any stray record
    repeat (TailCycles) begin
      @(posedge RClk);
      #2;
      driveCycle(1'b0, 1'b1);
    end

    @(posedge RClk);
    #2;
    driveCycle(1'b0, 1'b0);
    finalCheck = 1'b1;
    @(posedge RClk);
    #2;
    finalCheck = 1'b0;

    $display("errors: value %0d, other %0d", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
